//--- all.f
logic/core_pkg.sv
logic/pipe_if.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/exec_stage.sv
logic/mem_stage.sv
logic/commit_monitor.sv
logic/sim_top.sv
verif/clock_gen.sv
verif/tb_sim_top.sv

//--- logic/commit_monitor.sv
`default_nettype none

module commit_monitor
(
   input  wire                  clock,
   input  wire                  rst,
   pipe_if.dst                  i_m2c,
   input  wire core_pkg::xlen_t i_x10,

   output logic                 o_commit_valid,
   output core_pkg::xlen_t      o_commit_pc,
   output core_pkg::insn_t      o_commit_insn,
   output logic                 o_commit_wen,
   output logic [7:0]           o_commit_wdest,
   output core_pkg::xlen_t      o_commit_wdata,

   output logic                 o_trap_valid,
   output logic [7:0]           o_trap_code,
   output logic [63:0]          o_cycle_cnt,
   output logic [63:0]          o_instr_cnt
);

   assign i_m2c.stall = 1'b0;   // Pure observer

   always_ff @(posedge clock)
      if (rst)
         begin
            o_commit_valid <= 1'b0;
            o_trap_valid   <= 1'b0;
            o_cycle_cnt    <= '0;
            o_instr_cnt    <= '0;
         end
      else
         begin
            o_commit_valid <= i_m2c.valid;
            o_commit_pc    <= i_m2c.pc;
            o_commit_insn  <= i_m2c.insn;
            o_commit_wen   <= i_m2c.rf_we && (i_m2c.rd != '0);
            o_commit_wdest <= {3'b000, i_m2c.rd};
            o_commit_wdata <= i_m2c.result;

            // Earlier writes to x10 have already landed
            o_trap_valid <= i_m2c.valid && i_m2c.is_trap;
            o_trap_code  <= i_x10[7:0];

            if (i_m2c.valid)
               o_instr_cnt <= o_instr_cnt + 64'd1;   // Includes the trap itself
            o_cycle_cnt <= o_cycle_cnt + 64'd1;
         end

endmodule

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

   // Widths that carry a meaning
   typedef logic [63:0] xlen_t;     // Register value or data word
   typedef logic [31:0] insn_t;
   typedef logic [4:0]  reg_idx_t;

   // Major opcodes
   localparam logic [6:0] OP_IMM   = 7'b0010011;
   localparam logic [6:0] OP_REG   = 7'b0110011;
   localparam logic [6:0] OP_LOAD  = 7'b0000011;
   localparam logic [6:0] OP_STORE = 7'b0100011;
   localparam logic [6:0] OP_TRAP  = 7'h6b;     // Simulation trap, code in x10

   // funct3 values
   localparam logic [2:0] F3_ADD   = 3'b000;
   localparam logic [2:0] F3_XOR   = 3'b100;
   localparam logic [2:0] F3_OR    = 3'b110;
   localparam logic [2:0] F3_AND   = 3'b111;
   localparam logic [2:0] F3_LD_SD = 3'b011;    // Doubleword access

   localparam logic [6:0] F7_SUB   = 7'b0100000;

   typedef enum logic
   {
      FETCH_RUN,
      FETCH_HALT
   } fetch_state_e;

endpackage

`default_nettype wire

//--- logic/exec_stage.sv
`default_nettype none

module exec_stage
(
   input  wire                     clock,
   input  wire                     rst,
   pipe_if.dst                     i_f2e,
   pipe_if.src                     o_e2m,
   output core_pkg::reg_idx_t      o_rs1_idx,
   output core_pkg::reg_idx_t      o_rs2_idx,
   input  wire core_pkg::xlen_t    i_rs1_dat,
   input  wire core_pkg::xlen_t    i_rs2_dat,
   output logic                    o_halt
);
   import core_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_idx_t   rd_idx;
   xlen_t      imm_i;
   xlen_t      imm_s;
   xlen_t      alu_res;
   logic       rf_we_d;
   logic       is_load_d;
   logic       is_store_d;
   logic       is_trap_d;
   logic       uses_rs1;
   logic       uses_rs2;
   logic       hazard;
   logic       take;
   logic       trapped_q;   // Everything behind the trap is dropped

   assign opcode    = i_f2e.insn[6:0];
   assign rd_idx    = i_f2e.insn[11:7];
   assign funct3    = i_f2e.insn[14:12];
   assign funct7    = i_f2e.insn[31:25];
   assign o_rs1_idx = i_f2e.insn[19:15];
   assign o_rs2_idx = i_f2e.insn[24:20];
   assign imm_i     = {{52{i_f2e.insn[31]}}, i_f2e.insn[31:20]};
   assign imm_s     = {{52{i_f2e.insn[31]}}, i_f2e.insn[31:25], i_f2e.insn[11:7]};

   always_comb
      begin
         alu_res    = i_rs1_dat + imm_i;
         rf_we_d    = 1'b0;
         is_load_d  = 1'b0;
         is_store_d = 1'b0;
         is_trap_d  = 1'b0;
         uses_rs1   = 1'b1;
         uses_rs2   = 1'b0;
         case (opcode)
            OP_IMM:
               rf_we_d = (funct3 == F3_ADD);
            OP_REG:
               begin
                  uses_rs2 = 1'b1;
                  rf_we_d  = 1'b1;
                  case (funct3)
                     F3_ADD:
                        alu_res = (funct7 == F7_SUB) ? i_rs1_dat - i_rs2_dat
                                                     : i_rs1_dat + i_rs2_dat;
                     F3_XOR:  alu_res = i_rs1_dat ^ i_rs2_dat;
                     F3_OR:   alu_res = i_rs1_dat | i_rs2_dat;
                     F3_AND:  alu_res = i_rs1_dat & i_rs2_dat;
                     default: rf_we_d = 1'b0;
                  endcase
               end
            OP_LOAD:
               begin
                  is_load_d = (funct3 == F3_LD_SD);
                  rf_we_d   = is_load_d;
               end
            OP_STORE:
               begin
                  uses_rs2   = 1'b1;
                  is_store_d = (funct3 == F3_LD_SD);
                  alu_res    = i_rs1_dat + imm_s;
               end
            OP_TRAP:
               begin
                  uses_rs1  = 1'b0;
                  is_trap_d = 1'b1;
               end
            default:
               uses_rs1 = 1'b0;   // Unknown, commits without a write
         endcase
      end

   // Producer still in e2m has not reached the register file yet
   assign hazard = i_f2e.valid && !trapped_q && o_e2m.valid && o_e2m.rf_we
                   && (o_e2m.rd != '0)
                   && ((uses_rs1 && o_rs1_idx == o_e2m.rd) || (uses_rs2 && o_rs2_idx == o_e2m.rd));

   assign i_f2e.stall = hazard || o_e2m.stall;
   assign take        = i_f2e.valid && !i_f2e.stall;
   assign o_halt      = i_f2e.valid && is_trap_d && !trapped_q;

   always_ff @(posedge clock)
      if (rst)
         begin
            o_e2m.valid <= 1'b0;
            trapped_q   <= 1'b0;
         end
      else
         begin
            if (take && is_trap_d)
               trapped_q <= 1'b1;

            if (!o_e2m.stall)
               begin
                  o_e2m.valid      <= take && !trapped_q;
                  o_e2m.pc         <= i_f2e.pc;
                  o_e2m.insn       <= i_f2e.insn;
                  o_e2m.rd         <= rd_idx;
                  o_e2m.rf_we      <= rf_we_d;
                  o_e2m.is_load    <= is_load_d;
                  o_e2m.is_store   <= is_store_d;
                  o_e2m.is_trap    <= is_trap_d;
                  o_e2m.result     <= alu_res;
                  o_e2m.store_data <= i_rs2_dat;
               end
         end

   // Fetch must not deliver anything behind the trap
   a_halt_drains: assert property (@(posedge clock) disable iff (rst)
      (o_halt && !i_f2e.stall) |=> !i_f2e.valid);

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`default_nettype none

module fetch_stage
#(
   parameter int IRAM_AW = 8
)
(
   input  wire                  clock,
   input  wire                  rst,
   input  wire                  i_load_we,
   input  wire [IRAM_AW-1:0]    i_load_addr,
   input  wire core_pkg::insn_t i_load_data,
   input  wire                  i_halt,
   pipe_if.src                  o_f2e
);
   import core_pkg::*;

   insn_t        iram [2**IRAM_AW];
   fetch_state_e state_q;
   xlen_t        pc_q;      // Address of the next read
   logic         rd_en;

   // Hold the current item while execute stalls it
   assign rd_en = (state_q == FETCH_RUN) && !i_halt && !(o_f2e.valid && o_f2e.stall);

   always_ff @(posedge clock)
      if (i_load_we)
         iram[i_load_addr] <= i_load_data;

   always_ff @(posedge clock)
      if (rst)
         begin
            state_q     <= FETCH_RUN;
            pc_q        <= '0;
            o_f2e.valid <= 1'b0;
         end
      else
         begin
            if (i_halt)
               state_q <= FETCH_HALT;

            if (rd_en)
               begin
                  o_f2e.insn <= iram[pc_q[IRAM_AW+1:2]];
                  o_f2e.pc   <= pc_q;
                  pc_q       <= pc_q + 64'd4;
               end

            o_f2e.valid <= rd_en || (o_f2e.valid && o_f2e.stall);
         end

   // Decode happens in execute
   assign o_f2e.rd         = '0;
   assign o_f2e.rf_we      = 1'b0;
   assign o_f2e.is_load    = 1'b0;
   assign o_f2e.is_store   = 1'b0;
   assign o_f2e.is_trap    = 1'b0;
   assign o_f2e.result     = '0;
   assign o_f2e.store_data = '0;

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
`default_nettype none

module mem_stage
#(
   parameter int DRAM_AW = 8
)
(
   input  wire                  clock,
   input  wire                  rst,
   input  wire                  i_load_we,
   input  wire [DRAM_AW-1:0]    i_load_addr,
   input  wire core_pkg::xlen_t i_load_data,
   pipe_if.dst                  i_e2m,
   pipe_if.src                  o_m2c
);
   import core_pkg::*;

   xlen_t              dram [2**DRAM_AW];
   logic [DRAM_AW-1:0] word_idx;

   assign word_idx    = i_e2m.result[DRAM_AW+2:3];   // Doubleword index
   assign i_e2m.stall = 1'b0;

   always_ff @(posedge clock)
      if (i_load_we)
         dram[i_load_addr] <= i_load_data;
      else if (i_e2m.valid && i_e2m.is_store)
         dram[word_idx] <= i_e2m.store_data;

   always_ff @(posedge clock)
      if (rst)
         o_m2c.valid <= 1'b0;
      else
         begin
            o_m2c.valid      <= i_e2m.valid;
            o_m2c.pc         <= i_e2m.pc;
            o_m2c.insn       <= i_e2m.insn;
            o_m2c.rd         <= i_e2m.rd;
            o_m2c.rf_we      <= i_e2m.rf_we;
            o_m2c.is_load    <= i_e2m.is_load;
            o_m2c.is_store   <= i_e2m.is_store;
            o_m2c.is_trap    <= i_e2m.is_trap;
            o_m2c.store_data <= i_e2m.store_data;
            // Loaded word replaces the address
            o_m2c.result     <= i_e2m.is_load ? dram[word_idx] : i_e2m.result;
         end

   a_ld_sd_excl: assert property (@(posedge clock) disable iff (rst)
      i_e2m.valid |-> !(i_e2m.is_load && i_e2m.is_store));

   // No holding register here, so the commit side may never push back
   a_m2c_no_stall: assert property (@(posedge clock) disable iff (rst)
      o_m2c.valid |-> !o_m2c.stall);

endmodule

`default_nettype wire

//--- logic/pipe_if.sv
`default_nettype none

// One instruction moving between two pipeline stages
interface pipe_if;
   import core_pkg::*;

   logic     valid;
   logic     stall;        // Back from the receiving stage
   xlen_t    pc;
   insn_t    insn;
   reg_idx_t rd;
   logic     rf_we;
   logic     is_load;
   logic     is_store;
   logic     is_trap;
   xlen_t    result;       // ALU value or memory address
   xlen_t    store_data;

   modport src
   (
      output valid, pc, insn, rd, rf_we, is_load, is_store, is_trap, result, store_data,
      input  stall
   );

   modport dst
   (
      input  valid, pc, insn, rd, rf_we, is_load, is_store, is_trap, result, store_data,
      output stall
   );

endinterface

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file
(
   input  wire                     clock,
   input  wire                     rst,
   input  wire core_pkg::reg_idx_t i_rs1_idx,
   input  wire core_pkg::reg_idx_t i_rs2_idx,
   output core_pkg::xlen_t         o_rs1_dat,
   output core_pkg::xlen_t         o_rs2_dat,
   input  wire                     i_we,
   input  wire core_pkg::reg_idx_t i_rd,
   input  wire core_pkg::xlen_t    i_rd_dat,
   output core_pkg::xlen_t         o_x10
);
   import core_pkg::*;

   xlen_t regs [32];

   // Write-first, so a commit in the same cycle is seen by decode
   function automatic xlen_t read_port(reg_idx_t idx);
      if (idx == '0)
         return '0;
      else if (i_we && idx == i_rd)
         return i_rd_dat;
      return regs[idx];
   endfunction

   always_ff @(posedge clock)
      if (rst)
         begin
            for (int i = 0; i < 32; i++)
               regs[i] <= '0;
         end
      else if (i_we && i_rd != '0)
         regs[i_rd] <= i_rd_dat;

   always_comb
      begin
         o_rs1_dat = read_port(i_rs1_idx);
         o_rs2_dat = read_port(i_rs2_idx);
      end

   assign o_x10 = regs[10];   // Trap exit code

endmodule

`default_nettype wire

//--- logic/sim_top.sv
`default_nettype none

module sim_top
#(
   parameter int IRAM_AW = 8,
   parameter int DRAM_AW = 8
)
(
   input  wire                  clock,
   input  wire                  rst,

   input  wire                  i_load_we,
   input  wire                  i_load_sel,    // 0 selects IRAM, 1 selects DRAM
   input  wire [7:0]            i_load_addr,
   input  wire core_pkg::xlen_t i_load_data,

   output logic                 o_commit_valid,
   output core_pkg::xlen_t      o_commit_pc,
   output core_pkg::insn_t      o_commit_insn,
   output logic                 o_commit_wen,
   output logic [7:0]           o_commit_wdest,
   output core_pkg::xlen_t      o_commit_wdata,

   output logic                 o_trap_valid,
   output logic [7:0]           o_trap_code,
   output logic [63:0]          o_cycle_cnt,
   output logic [63:0]          o_instr_cnt
);
   import core_pkg::*;

   logic [3:0] rst_rr = 4'hf;
   logic       core_rst;
   logic       iram_we;
   logic       dram_we;
   logic       halt;
   reg_idx_t   rs1_idx;
   reg_idx_t   rs2_idx;
   xlen_t      rs1_dat;
   xlen_t      rs2_dat;
   xlen_t      x10;

   pipe_if f2e ();
   pipe_if e2m ();
   pipe_if m2c ();

   // Core leaves reset four cycles after rst drops
   always_ff @(posedge clock)
      rst_rr <= {rst_rr[2:0], rst};
   assign core_rst = rst_rr[3];

   assign iram_we = i_load_we && !i_load_sel;
   assign dram_we = i_load_we && i_load_sel;

   fetch_stage #(.IRAM_AW (IRAM_AW)) fetch_i
   (
      .clock       (clock),
      .rst         (core_rst),
      .i_load_we   (iram_we),
      .i_load_addr (i_load_addr[IRAM_AW-1:0]),
      .i_load_data (i_load_data[31:0]),
      .i_halt      (halt),
      .o_f2e       (f2e.src)
   );

   exec_stage exec_i
   (
      .clock     (clock),
      .rst       (core_rst),
      .i_f2e     (f2e.dst),
      .o_e2m     (e2m.src),
      .o_rs1_idx (rs1_idx),
      .o_rs2_idx (rs2_idx),
      .i_rs1_dat (rs1_dat),
      .i_rs2_dat (rs2_dat),
      .o_halt    (halt)
   );

   reg_file rf_i
   (
      .clock     (clock),
      .rst       (core_rst),
      .i_rs1_idx (rs1_idx),
      .i_rs2_idx (rs2_idx),
      .o_rs1_dat (rs1_dat),
      .o_rs2_dat (rs2_dat),
      .i_we      (m2c.valid && m2c.rf_we),
      .i_rd      (m2c.rd),
      .i_rd_dat  (m2c.result),
      .o_x10     (x10)
   );

   mem_stage #(.DRAM_AW (DRAM_AW)) mem_i
   (
      .clock       (clock),
      .rst         (core_rst),
      .i_load_we   (dram_we),
      .i_load_addr (i_load_addr[DRAM_AW-1:0]),
      .i_load_data (i_load_data),
      .i_e2m       (e2m.dst),
      .o_m2c       (m2c.src)
   );

   commit_monitor commit_i
   (
      .clock          (clock),
      .rst            (core_rst),
      .i_m2c          (m2c.dst),
      .i_x10          (x10),
      .o_commit_valid (o_commit_valid),
      .o_commit_pc    (o_commit_pc),
      .o_commit_insn  (o_commit_insn),
      .o_commit_wen   (o_commit_wen),
      .o_commit_wdest (o_commit_wdest),
      .o_commit_wdata (o_commit_wdata),
      .o_trap_valid   (o_trap_valid),
      .o_trap_code    (o_trap_code),
      .o_cycle_cnt    (o_cycle_cnt),
      .o_instr_cnt    (o_instr_cnt)
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sim_top testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_sim_top -f all.f -o tb_sim_top
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/tb_sim_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
   exit 0
else
   echo "Pass line not found in sim.log"
   exit 1
fi

//--- verif/clock_gen.sv
`default_nettype none

module clock_gen
#(
   parameter int PERIOD = 20
)
(
   output logic o_clock
);

   initial
      o_clock = 1'b0;

   always
      #(PERIOD / 2) o_clock = ~o_clock;

endmodule

`default_nettype wire

//--- verif/tb_sim_top.sv
`default_nettype none

module tb_sim_top;
   import core_pkg::*;

   logic        clock;
   logic        rst;
   logic        load_we;
   logic        load_sel;
   logic [7:0]  load_addr;
   xlen_t       load_data;
   logic        commit_valid;
   xlen_t       commit_pc;
   insn_t       commit_insn;
   logic        commit_wen;
   logic [7:0]  commit_wdest;
   xlen_t       commit_wdata;
   logic        trap_valid;
   logic [7:0]  trap_code;
   logic [63:0] cycle_cnt;
   logic [63:0] instr_cnt;

   int          seed = 35170;
   insn_t       prog [$];
   logic [7:0]  data_addr [$];
   xlen_t       data_val [$];
   xlen_t       exp_pc [$];
   insn_t       exp_insn [$];
   logic        exp_wen [$];
   reg_idx_t    exp_rd [$];
   xlen_t       exp_wdata [$];
   logic [7:0]  exp_code;
   xlen_t       model_rf [32];
   xlen_t       model_dm [256];   // Kept across runs like the data RAM

   clock_gen #(.PERIOD (20)) clk_i (.o_clock (clock));

   sim_top sim_top_i
   (
      .clock          (clock),
      .rst            (rst),
      .i_load_we      (load_we),
      .i_load_sel     (load_sel),
      .i_load_addr    (load_addr),
      .i_load_data    (load_data),
      .o_commit_valid (commit_valid),
      .o_commit_pc    (commit_pc),
      .o_commit_insn  (commit_insn),
      .o_commit_wen   (commit_wen),
      .o_commit_wdest (commit_wdest),
      .o_commit_wdata (commit_wdata),
      .o_trap_valid   (trap_valid),
      .o_trap_code    (trap_code),
      .o_cycle_cnt    (cycle_cnt),
      .o_instr_cnt    (instr_cnt)
   );

   task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
      if (got !== expected)
         begin
            $display("** Error: %s is %h, expected %h", name, got, expected);
            $display("Finished with errors");
            $fatal(1);
         end
   endtask

   function automatic xlen_t sext12(logic [11:0] imm);
      return {{52{imm[11]}}, imm};
   endfunction

   function logic [11:0] rand_imm();
      return 12'($random(seed));
   endfunction

   function reg_idx_t pick_reg(int lo, int hi);
      return reg_idx_t'(lo + ($unsigned($random(seed)) % (hi - lo + 1)));
   endfunction

   task automatic new_program();
      prog.delete();
      data_addr.delete();
      data_val.delete();
      exp_pc.delete();
      exp_insn.delete();
      exp_wen.delete();
      exp_rd.delete();
      exp_wdata.delete();
      for (int i = 0; i < 32; i++)
         model_rf[i] = '0;   // Core reset clears the registers
   endtask

   task automatic preload_word(logic [7:0] addr, xlen_t value);
      data_addr.push_back(addr);
      data_val.push_back(value);
      model_dm[addr] = value;
   endtask

   // Append one instruction and its expected commit record
   task automatic emit(insn_t insn, logic wen, reg_idx_t rd, xlen_t wdata);
      exp_pc.push_back(xlen_t'(prog.size()) * 4);
      exp_insn.push_back(insn);
      exp_wen.push_back(wen && rd != 0);
      exp_rd.push_back(rd);
      exp_wdata.push_back(wdata);
      prog.push_back(insn);
      if (wen && rd != 0)
         model_rf[rd] = wdata;
   endtask

   task automatic op_addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
      emit({imm, rs1, F3_ADD, rd, OP_IMM}, 1'b1, rd, model_rf[rs1] + sext12(imm));
   endtask

   task automatic op_reg(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                         reg_idx_t rs2);
      xlen_t a;
      xlen_t b;
      xlen_t r;
      a = model_rf[rs1];
      b = model_rf[rs2];
      case (f3)
         F3_XOR:  r = a ^ b;
         F3_OR:   r = a | b;
         F3_AND:  r = a & b;
         default: r = (f7 == F7_SUB) ? a - b : a + b;
      endcase
      emit({f7, rs2, rs1, f3, rd, OP_REG}, 1'b1, rd, r);
   endtask

   task automatic op_sd(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
      xlen_t addr;
      addr = model_rf[rs1] + sext12(imm);
      model_dm[addr[10:3]] = model_rf[rs2];
      emit({imm[11:5], rs2, rs1, F3_LD_SD, imm[4:0], OP_STORE}, 1'b0, imm[4:0], addr);
   endtask

   task automatic op_ld(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
      xlen_t addr;
      addr = model_rf[rs1] + sext12(imm);
      emit({imm, rs1, F3_LD_SD, rd, OP_LOAD}, 1'b1, rd, model_dm[addr[10:3]]);
   endtask

   task automatic op_trap();
      exp_code = model_rf[10][7:0];
      emit(32'h0000006b, 1'b0, 5'd0, '0);
   endtask

   // Load both memories under reset, release it and follow the commits
   task automatic run_program();
      int limit;
      int cycles;
      int idx;
      int quiet;
      bit done;
      limit = 40 * prog.size() + 200;
      @(posedge clock);
      rst <= 1'b1;
      for (int i = 0; i < prog.size(); i++)
         begin
            @(posedge clock);
            load_we   <= 1'b1;
            load_sel  <= 1'b0;
            load_addr <= 8'(i);
            load_data <= xlen_t'(prog[i]);
         end
      for (int i = 0; i < data_addr.size(); i++)
         begin
            @(posedge clock);
            load_we   <= 1'b1;
            load_sel  <= 1'b1;
            load_addr <= data_addr[i];
            load_data <= data_val[i];
         end
      @(posedge clock);
      load_we <= 1'b0;
      for (int i = 0; i < 10; i++)
         begin
            @(negedge clock);
            check_value("o_commit_valid", commit_valid, 0);
            check_value("o_trap_valid", trap_valid, 0);
            check_value("o_instr_cnt", instr_cnt, 0);
            check_value("o_cycle_cnt", cycle_cnt, 0);
         end
      @(posedge clock);
      rst <= 1'b0;
      idx    = 0;
      cycles = 0;
      quiet  = 0;
      done   = 1'b0;
      while (!done || quiet < 20)   // Watch a while after the trap
         begin
            @(negedge clock);
            cycles++;
            if (cycles > limit)
               begin
                  $display("Timeout after %0d cycles, %0d of %0d commits seen",
                           cycles, idx, exp_pc.size());
                  $display("Finished with errors");
                  $fatal(1);
               end
            else if (commit_valid && idx >= exp_pc.size())
               begin
                  $display("Unexpected commit at pc %h after the trap", commit_pc);
                  $display("Finished with errors");
                  $fatal(1);
               end
            else if (commit_valid)
               begin
                  check_value("o_commit_pc", commit_pc, exp_pc[idx]);
                  check_value("o_commit_insn", commit_insn, exp_insn[idx]);
                  check_value("o_commit_wen", commit_wen, exp_wen[idx]);
                  if (exp_wen[idx])
                     begin
                        check_value("o_commit_wdest", commit_wdest, exp_rd[idx]);
                        check_value("o_commit_wdata", commit_wdata, exp_wdata[idx]);
                     end
                  check_value("o_trap_valid", trap_valid, idx == exp_pc.size() - 1);
                  if (trap_valid)
                     begin
                        check_value("o_trap_code", trap_code, exp_code);
                        check_value("o_instr_cnt", instr_cnt, idx + 1);
                        // Core leaves reset four edges after rst, then counts every edge
                        check_value("o_cycle_cnt", cycle_cnt, cycles - 5);
                        done = 1'b1;
                     end
                  idx++;
               end
            else
               check_value("o_trap_valid", trap_valid, 0);
            if (done)
               quiet++;
         end
   endtask

   task automatic test_alu_random();
      new_program();
      for (int i = 0; i < 4; i++)
         begin
            preload_word(8'(i), {$random(seed), $random(seed)});
            op_ld(reg_idx_t'(i + 1), 5'd0, 12'(8 * i));
         end
      for (int i = 0; i < 16; i++)
         case ($unsigned($random(seed)) % 6)
            0: op_addi(pick_reg(5, 9), pick_reg(1, 9), rand_imm());
            1: op_reg(7'd0, F3_ADD, pick_reg(5, 9), pick_reg(1, 9), pick_reg(1, 9));
            2: op_reg(F7_SUB, F3_ADD, pick_reg(5, 9), pick_reg(1, 9), pick_reg(1, 9));
            3: op_reg(7'd0, F3_AND, pick_reg(5, 9), pick_reg(1, 9), pick_reg(1, 9));
            4: op_reg(7'd0, F3_OR, pick_reg(5, 9), pick_reg(1, 9), pick_reg(1, 9));
            default: op_reg(7'd0, F3_XOR, pick_reg(5, 9), pick_reg(1, 9), pick_reg(1, 9));
         endcase
      op_reg(7'd0, F3_XOR, 5'd10, pick_reg(1, 9), pick_reg(1, 9));
      op_trap();
      run_program();
   endtask

   task automatic test_x0_writes();
      new_program();
      op_addi(5'd0, 5'd0, rand_imm());
      op_addi(5'd1, 5'd0, rand_imm());
      op_reg(7'd0, F3_ADD, 5'd0, 5'd1, 5'd1);
      op_reg(7'd0, F3_OR, 5'd2, 5'd0, 5'd1);   // x0 must read zero here
      op_reg(F7_SUB, F3_ADD, 5'd10, 5'd2, 5'd0);
      op_trap();
      run_program();
   endtask

   task automatic test_dependent_chains();
      new_program();
      op_addi(5'd1, 5'd0, rand_imm());
      for (int i = 0; i < 4; i++)
         op_addi(5'd1, 5'd1, rand_imm());
      op_reg(7'd0, F3_ADD, 5'd2, 5'd1, 5'd1);
      op_reg(F7_SUB, F3_ADD, 5'd3, 5'd2, 5'd1);
      op_reg(7'd0, F3_AND, 5'd4, 5'd3, 5'd2);
      op_reg(7'd0, F3_OR, 5'd5, 5'd4, 5'd1);
      op_reg(7'd0, F3_XOR, 5'd10, 5'd5, 5'd3);
      op_trap();
      run_program();
   endtask

   task automatic test_load_store();
      new_program();
      preload_word(8'd40, {$random(seed), $random(seed)});
      op_ld(5'd2, 5'd0, 12'd320);
      op_addi(5'd3, 5'd0, rand_imm());
      op_sd(5'd3, 5'd0, 12'd800);
      op_ld(5'd4, 5'd0, 12'd800);
      op_addi(5'd5, 5'd0, 12'd512);
      op_sd(5'd2, 5'd5, 12'd8);
      op_ld(5'd6, 5'd5, 12'd8);
      op_reg(7'd0, F3_ADD, 5'd10, 5'd4, 5'd6);
      op_trap();
      run_program();
   endtask

   initial
      begin
         rst       <= 1'b1;
         load_we   <= 1'b0;
         load_sel  <= 1'b0;
         load_addr <= '0;
         load_data <= '0;
         test_alu_random();
         test_x0_writes();
         test_dependent_chains();
         test_load_store();
         $display("Finished with no errors");
         $finish;
      end

endmodule

`default_nettype wire
